// File: testbench/executeCore_tests.txt
# instr    opDest   opFirst  opSec    reply    kind value    addr     flags
# kind W register write, M store, B branch taken, N nothing; addr is read/store address or target
42123000 00000000 00000005 00000007 00000000 W 0000000c 00000000 0
52312000 00000000 ffffffff 00000001 00000000 W 00000000 00000000 6
54412000 00000000 80000000 00000001 00000000 W 7fffffff 00000000 3
56512000 00000000 f0f0f0f0 8000000f 00000000 W 80000000 00000000 b
58612000 00000000 00000000 00000000 00000000 W 00000000 00000000 7
4a712000 00000000 0f0f0000 00ff00ff 00000000 W 0ff000ff 00000000 7
4c810000 00000000 12345678 00000000 00000000 W edcba987 00000000 7
2291fffe 00000000 00000010 deadbeef 00000000 W 0000000e 00000000 7
34a10005 00000000 00000003 00000000 00000000 W fffffffe 00000000 8
28b18000 00000000 00000001 00000000 00000000 W ffff8001 00000000 8
00c0abcd 00000000 00000000 00000000 00000000 W 0000abcd 00000000 8
02d01234 aaaa5555 00000000 00000000 00000000 W 12345555 00000000 8
04e00000 00000000 00000000 00000000 00000000 W 00000000 00000000 8
06f00000 00000000 00000000 00000000 00000000 W ffffffff 00000000 8
08120004 00000000 8000000f 00000000 00000000 W 000000f0 00000000 8
0a22001f 00000000 80000000 00000000 00000000 W 00000001 00000000 8
1c000000 0000000d 00000000 00000000 00000000 N 00000000 00000000 d
0c300000 00000000 00000000 00000000 00000000 W 0000000d 00000000 d
c0000100 00000000 00000000 00000000 00000000 B 00000000 00000100 d
c4000200 00000000 00000000 00000000 00000000 N 00000000 00000200 d
c8000300 00000000 00000000 00000000 00000000 N 00000000 00000300 d
cc000400 00000000 00000000 00000000 00000000 B 00000000 00000400 d
d0000500 00000000 00000000 00000000 00000000 B 00000000 00000500 d
d4000600 00000000 00000000 00000000 00000000 N 00000000 00000600 d
d8000700 00000000 00000000 00000000 00000000 B 00000000 00000700 d
dc000800 00000000 00000000 00000000 00000000 N 00000000 00000800 d
e0000900 00000000 00000000 00000000 00000000 N 00000000 00000900 d
e4000a00 00000000 00000000 00000000 00000000 B 00000000 00000a00 d
e8000b00 00000000 00000000 00000000 00000000 B 00000000 00000b00 d
ec000c00 00000000 00000000 00000000 00000000 N 00000000 00000c00 d
f0000d00 00000000 00000000 00000000 00000000 N 00000000 00000d00 d
f4000e00 00000000 00000000 00000000 00000000 B 00000000 00000e00 d
1c000000 00000002 00000000 00000000 00000000 N 00000000 00000000 2
e0000f00 00000000 00000000 00000000 00000000 B 00000000 00000f00 2
f0001000 00000000 00000000 00000000 00000000 B 00000000 00001000 2
f8050010 00000000 00001230 00000000 00000000 B 00000000 00001240 2
a006fffc cafef00d 00002000 00000000 00000000 M cafef00d 00001ffc 2
52112000 00000000 7fffffff 00000001 00000000 W 80000000 00000000 9
d0001100 00000000 00000000 00000000 00000000 B 00000000 00001100 9
80370008 00000000 00000100 00000000 5a5aa5a5 W 5a5aa5a5 00000108 9

// File: tb.f
hw/isaPkg.sv
hw/execPkg.sv
hw/branchCondition.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/writebackStage.sv
hw/executeCore.sv
testbench/clockGen.sv
testbench/executeCore_checker.sv
testbench/executeCoreTb.sv

// File: run.sh
#!/bin/bash
# Builds and runs the executeCore testbench with Verilator

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module executeCoreTb -f tb.f -o executeCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/executeCoreSim +verilator+error+limit+100 > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulator exited with status $runStatus"
    exit 1
fi

if grep -qx "Simulation passed" "$logFile"; then
    exit 0
else
    echo "Pass message not found in $logFile"
    exit 1
fi

// File: testbench/executeCoreTb.sv
module executeCoreTb
    import isaPkg::*, execPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 16;
    localparam string testFile = "testbench/executeCore_tests.txt";

    typedef struct {
        instrWord instr;
        logic [dataWidth-1:0] opDest;
        logic [dataWidth-1:0] opFirst;
        logic [dataWidth-1:0] opSec;
        logic [dataWidth-1:0] reply;
        logic [7:0] kind;                // W, M, B or N
        logic [dataWidth-1:0] value;
        logic [dataWidth-1:0] addr;      // Read or store address or branch target
        flagWord flags;
    } testLine;

    logic clk;
    logic rst;
    logic instrValid;
    instrWord instr;
    logic [dataWidth-1:0] opDest;
    logic [dataWidth-1:0] opFirst;
    logic [dataWidth-1:0] opSec;
    logic [dataWidth-1:0] memoryReply;
    logic [dataWidth-1:0] memoryDataIn;
    logic memoryRead;
    logic [dataWidth-1:0] memoryAddress;
    logic memoryWrite;
    logic [dataWidth-1:0] memoryDataOut;
    logic writeValid;
    logic [regIndexWidth-1:0] writeReg;
    logic [dataWidth-1:0] writeData;
    logic branchTaken;
    logic [targetWidth-1:0] branchTarget;
    flagWord flags;

    testLine tests[$];
    int testErrs[$];
    int errorCount = 0;
    bit loaded = 1'b0;

    clockGen #(.periodNs(clkPeriod), .resetCycles(resetCycles)) clockGen_inst (
        .clk(clk),
        .rst(rst)
    );

    executeCore executeCore_inst (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .opDest(opDest),
        .opFirst(opFirst),
        .opSec(opSec),
        .memoryDataIn(memoryDataIn),
        .memoryRead(memoryRead),
        .memoryAddress(memoryAddress),
        .memoryWrite(memoryWrite),
        .memoryDataOut(memoryDataOut),
        .writeValid(writeValid),
        .writeReg(writeReg),
        .writeData(writeData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .flags(flags)
    );

    assign memoryDataIn = memoryRead ? memoryReply : '0;   // Memory answers in the read cycle

    task automatic loadTests(output bit ok);
        int fd;
        int n;
        string line;
        string kindStr;
        logic [dataWidth-1:0] f[8];
        logic [3:0] fl;
        testLine t;
        fd = $fopen(testFile, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %s %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], kindStr, f[5], f[6], fl);
                    if (n == 9) begin
                        t.instr = f[0];
                        t.opDest = f[1];
                        t.opFirst = f[2];
                        t.opSec = f[3];
                        t.reply = f[4];
                        t.kind = kindStr.getc(0);
                        t.value = f[5];
                        t.addr = f[6];
                        t.flags = fl;
                        tests.push_back(t);
                        testErrs.push_back(0);
                    end else begin
                        $display("Malformed line in test file: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            ok = ok && (tests.size() > 0);
        end
    endtask

    task automatic noteError(input int idx);
        testErrs[idx] = testErrs[idx] + 1;
        errorCount++;
    endtask

    task automatic checkWord(input int idx, input string what,
                             input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: test %0d %s is %h, expected %h", $time, idx, what, got, exp);
            noteError(idx);
        end
    endtask

    task automatic checkReg(input int idx, input logic [regIndexWidth-1:0] got,
                            input logic [regIndexWidth-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: test %0d writeReg is %0d, expected %0d", $time, idx, got, exp);
            noteError(idx);
        end
    endtask

    task automatic checkTarget(input int idx, input logic [targetWidth-1:0] got,
                               input logic [targetWidth-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: test %0d branchTarget is %h, expected %h", $time, idx, got, exp);
            noteError(idx);
        end
    endtask

    task automatic checkFlags(input int idx, input flagWord got, input flagWord exp);
        if (got !== exp) begin
            $display("ERR %0t: test %0d flags NZCV are %b, expected %b", $time, idx, got, exp);
            noteError(idx);
        end
    endtask

    task automatic checkStrobe(input int idx, input string what, input logic got, input bit exp);
        if (exp && got !== 1'b1) begin
            $display("Test %0d: %s did not come at time %0t", idx, what, $time);
            noteError(idx);
        end else if (!exp && got !== 1'b0) begin
            $display("Test %0d: unexpected %s at time %0t", idx, what, $time);
            noteError(idx);
        end
    endtask

    // Flags and the load read port one cycle after execute
    task automatic checkExecute(input int idx);
        testLine t;
        bit isLoad;
        t = tests[idx];
        isLoad = (t.instr.immediateView.cls == classLoadStore) && !t.instr.immediateView.special;
        checkFlags(idx, flags, t.flags);
        checkStrobe(idx, "memory read", memoryRead, isLoad);
        if (isLoad && memoryRead) begin
            checkWord(idx, "read address", memoryAddress, t.addr);
        end
    endtask

    task automatic checkResult(input int idx);
        testLine t;
        t = tests[idx];
        checkStrobe(idx, "register write", writeValid, t.kind == "W");
        checkStrobe(idx, "memory write", memoryWrite, t.kind == "M");
        checkStrobe(idx, "taken branch", branchTaken, t.kind == "B");
        if (t.kind == "W" && writeValid) begin
            checkReg(idx, writeReg, t.instr.registerView.dest);
            checkWord(idx, "writeData", writeData, t.value);
        end else if (t.kind == "M" && memoryWrite) begin
            checkWord(idx, "store address", memoryAddress, t.addr);
            checkWord(idx, "store data", memoryDataOut, t.value);
        end else if (t.kind == "B" && branchTaken) begin
            checkTarget(idx, branchTarget, t.addr[targetWidth-1:0]);
        end
        if (testErrs[idx] == 0) begin
            $display("test %0d (%c) ok", idx, t.kind);
        end else begin
            $display("test %0d (%c) failed with %0d errors", idx, t.kind, testErrs[idx]);
        end
    endtask

    // One issue per cycle with flags checked at E+1 and results at E+2
    task automatic runTests();
        int total;
        total = tests.size();
        for (int cyc = 0; cyc < total + 3; cyc++) begin
            @(posedge clk);
            if (cyc < total) begin
                instrValid <= 1'b1;
                instr <= tests[cyc].instr;
                opDest <= tests[cyc].opDest;
                opFirst <= tests[cyc].opFirst;
                opSec <= tests[cyc].opSec;
            end else begin
                instrValid <= 1'b0;
                instr <= '0;
            end
            if (cyc >= 2 && cyc < total + 2) begin
                memoryReply <= tests[cyc - 2].reply;
            end
            @(negedge clk);
            if (cyc >= 2 && cyc < total + 2) begin
                checkExecute(cyc - 2);
            end
            if (cyc >= 3) begin
                checkResult(cyc - 3);
            end
        end
    endtask

    initial begin
        bit ok;
        int failedTests;
        int assertFails;
        instrValid = 1'b0;
        instr = '0;
        opDest = '0;
        opFirst = '0;
        opSec = '0;
        memoryReply = '0;
        loadTests(ok);
        if (!ok) begin
            $display("Could not read the tests from %s", testFile);
            $display("Simulation failed");
            $finish;
        end else begin
            loaded = 1'b1;
            wait (rst === 1'b1);    // Whole reset pulse, rise then release
            wait (rst === 1'b0);
            runTests();
            failedTests = 0;
            foreach (testErrs[i]) begin
                if (testErrs[i] != 0) begin
                    failedTests++;
                end
            end
            assertFails = executeCore_inst.protocolCheck.failCount;
            $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                     tests.size(), tests.size() - failedTests, failedTests, errorCount,
                     assertFails);
            if (errorCount == 0 && assertFails == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // Four cycles per test plus the reset
    initial begin
        wait (loaded);
        #((tests.size() * 4 + resetCycles) * clkPeriod);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: testbench/executeCore_checker.sv
module executeCore_checker
    import execPkg::*;
(
    input logic clk,
    input logic rst,
    input logic memoryRead,
    input logic memoryWrite,
    input logic writeValid,
    input logic branchTaken,
    input flagWord flags
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;      // Read by the testbench at the end

    // At most one result per cycle
    strobesExclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({writeValid, memoryWrite, branchTaken}))
        else begin
            $error("more than one result strobe high");
            failCount++;
        end

    loadWritesBack: assert property (@(posedge clk) disable iff (rst)
        memoryRead |=> writeValid)
        else begin
            $error("memory read not followed by a register write");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk)
        rst |-> !(memoryRead || memoryWrite || writeValid || branchTaken) && flags == '0)
        else begin
            $error("strobe or flags active during reset");
            failCount++;
        end

endmodule

bind executeCore executeCore_checker protocolCheck (
    .clk(clk),
    .rst(rst),
    .memoryRead(memoryRead),
    .memoryWrite(memoryWrite),
    .writeValid(writeValid),
    .branchTaken(branchTaken),
    .flags(flags)
);

// File: testbench/clockGen.sv
module clockGen #(
    parameter int periodNs = 40,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: hw/executeCore.sv
module executeCore
    import isaPkg::*, execPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic instrValid,
    input  instrWord instr,
    input  logic [dataWidth-1:0] opDest,
    input  logic [dataWidth-1:0] opFirst,
    input  logic [dataWidth-1:0] opSec,
    input  logic [dataWidth-1:0] memoryDataIn,
    output logic memoryRead,
    output logic [dataWidth-1:0] memoryAddress,
    output logic memoryWrite,
    output logic [dataWidth-1:0] memoryDataOut,
    output logic writeValid,
    output logic [regIndexWidth-1:0] writeReg,
    output logic [dataWidth-1:0] writeData,
    output logic branchTaken,
    output logic [targetWidth-1:0] branchTarget,
    output flagWord flags
);

    // Decode to execute
    logic decValid;
    opKind decKind;
    logic decSetFlags;
    logic [3:0] decCond;
    logic [regIndexWidth-1:0] decDest;
    logic [dataWidth-1:0] decImm;
    logic [immWidth-1:0] decImmRaw;
    logic [dataWidth-1:0] decOpDest;
    logic [dataWidth-1:0] decOpFirst;
    logic [dataWidth-1:0] decOpSec;

    // Execute to writeback
    logic exeValid;
    opKind exeKind;
    logic [regIndexWidth-1:0] exeDest;
    logic [dataWidth-1:0] exeResult;
    logic [dataWidth-1:0] exeStoreData;
    logic exeTaken;
    logic [targetWidth-1:0] exeTarget;

    decodeStage decodeStage_inst (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .opDest(opDest),
        .opFirst(opFirst),
        .opSec(opSec),
        .decValid(decValid),
        .decKind(decKind),
        .decSetFlags(decSetFlags),
        .decCond(decCond),
        .decDest(decDest),
        .decImm(decImm),
        .decImmRaw(decImmRaw),
        .decOpDest(decOpDest),
        .decOpFirst(decOpFirst),
        .decOpSec(decOpSec)
    );

    executeStage executeStage_inst (
        .clk(clk),
        .rst(rst),
        .decValid(decValid),
        .decKind(decKind),
        .decSetFlags(decSetFlags),
        .decCond(decCond),
        .decDest(decDest),
        .decImm(decImm),
        .decImmRaw(decImmRaw),
        .decOpDest(decOpDest),
        .decOpFirst(decOpFirst),
        .decOpSec(decOpSec),
        .exeValid(exeValid),
        .exeKind(exeKind),
        .exeDest(exeDest),
        .exeResult(exeResult),
        .exeStoreData(exeStoreData),
        .exeTaken(exeTaken),
        .exeTarget(exeTarget),
        .flags(flags)
    );

    writebackStage writebackStage_inst (
        .clk(clk),
        .rst(rst),
        .exeValid(exeValid),
        .exeKind(exeKind),
        .exeDest(exeDest),
        .exeResult(exeResult),
        .exeStoreData(exeStoreData),
        .exeTaken(exeTaken),
        .exeTarget(exeTarget),
        .memoryDataIn(memoryDataIn),
        .memoryRead(memoryRead),
        .memoryAddress(memoryAddress),
        .memoryWrite(memoryWrite),
        .memoryDataOut(memoryDataOut),
        .writeValid(writeValid),
        .writeReg(writeReg),
        .writeData(writeData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

endmodule

// File: hw/writebackStage.sv
module writebackStage
    import isaPkg::*, execPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic exeValid,
    input  opKind exeKind,
    input  logic [regIndexWidth-1:0] exeDest,
    input  logic [dataWidth-1:0] exeResult,
    input  logic [dataWidth-1:0] exeStoreData,
    input  logic exeTaken,
    input  logic [targetWidth-1:0] exeTarget,
    input  logic [dataWidth-1:0] memoryDataIn,
    output logic memoryRead,
    output logic [dataWidth-1:0] memoryAddress,
    output logic memoryWrite,
    output logic [dataWidth-1:0] memoryDataOut,
    output logic writeValid,
    output logic [regIndexWidth-1:0] writeReg,
    output logic [dataWidth-1:0] writeData,
    output logic branchTaken,
    output logic [targetWidth-1:0] branchTarget
);

    logic writesReg;
    logic [dataWidth-1:0] storeAddress;

    // Load reads the memory in the cycle after execute
    assign memoryRead = exeValid && (exeKind == opLoad);
    // A load directly behind a store gets the bus; the store address is lost then
    assign memoryAddress = memoryRead ? exeResult : storeAddress;

    always_comb begin
        case (exeKind)
            opWriteFlags, opStore, opBranch, opNone: writesReg = 1'b0;
            default: writesReg = exeValid;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            writeValid <= 1'b0;
            memoryWrite <= 1'b0;
            branchTaken <= 1'b0;
        end else begin
            writeValid <= writesReg;
            memoryWrite <= exeValid && (exeKind == opStore);
            branchTaken <= exeValid && (exeKind == opBranch) && exeTaken;
        end
    end

    always_ff @(posedge clk) begin
        writeReg <= exeDest;
        writeData <= memoryRead ? memoryDataIn : exeResult;
        storeAddress <= exeResult;
        memoryDataOut <= exeStoreData;
        branchTarget <= exeTarget;
    end

endmodule

// File: hw/executeStage.sv
module executeStage
    import isaPkg::*, execPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic decValid,
    input  opKind decKind,
    input  logic decSetFlags,
    input  logic [3:0] decCond,
    input  logic [regIndexWidth-1:0] decDest,
    input  logic [dataWidth-1:0] decImm,
    input  logic [immWidth-1:0] decImmRaw,
    input  logic [dataWidth-1:0] decOpDest,
    input  logic [dataWidth-1:0] decOpFirst,
    input  logic [dataWidth-1:0] decOpSec,
    output logic exeValid,
    output opKind exeKind,
    output logic [regIndexWidth-1:0] exeDest,
    output logic [dataWidth-1:0] exeResult,
    output logic [dataWidth-1:0] exeStoreData,
    output logic exeTaken,
    output logic [targetWidth-1:0] exeTarget,
    output flagWord flags
);

    localparam int msb = dataWidth - 1;

    logic [dataWidth:0] addSum;
    logic [dataWidth:0] subDiff;
    logic [dataWidth-1:0] addrSum;
    logic [dataWidth-1:0] result;
    logic [shiftWidth-1:0] shamt;
    logic [targetWidth-1:0] target;
    logic condTaken;
    flagWord flagsNext;

    assign addSum = {1'b0, decOpFirst} + {1'b0, decOpSec};
    assign subDiff = {1'b0, decOpFirst} - {1'b0, decOpSec};
    assign addrSum = decOpFirst + decImm;            // Load/store address and BR target
    assign shamt = decImmRaw[shiftWidth-1:0];

    branchCondition branchCondition_inst (
        .cond(decCond),
        .flags(flags),
        .taken(condTaken)
    );

    assign target = (decCond == condBr) ? addrSum[targetWidth-1:0] : decImmRaw;

    always_comb begin
        case (decKind)
            opAdd: result = addSum[msb:0];
            opSub: result = subDiff[msb:0];
            opAnd: result = decOpFirst & decOpSec;
            opOr: result = decOpFirst | decOpSec;
            opXor: result = decOpFirst ^ decOpSec;
            opNot: result = ~decOpFirst;
            opPassImm: result = {{(dataWidth - immWidth){1'b0}}, decImmRaw};
            opMoveTop: result = {decImmRaw, decOpDest[immWidth-1:0]};  // Keeps low half
            opZero: result = '0;
            opOnes: result = '1;
            opShiftLeft: result = decOpFirst << shamt;
            opShiftRight: result = decOpFirst >> shamt;
            opReadFlags: result = {{(dataWidth - flagWidth){1'b0}}, flags};
            opLoad, opStore: result = addrSum;
            default: result = '0;
        endcase
    end

    always_comb begin
        flagsNext = flags;
        if (decValid && decKind == opWriteFlags) begin
            flagsNext = decOpDest[flagWidth-1:0];
        end else if (decValid && decSetFlags) begin
            flagsNext[flagN] = result[msb];
            flagsNext[flagZ] = (result == '0);
            // C and V only from arithmetic, logic ops leave them alone
            if (decKind == opAdd) begin
                flagsNext[flagC] = addSum[dataWidth];
                flagsNext[flagV] = ~(decOpFirst[msb] ^ decOpSec[msb])
                                 & (decOpFirst[msb] ^ result[msb]);
            end else if (decKind == opSub) begin
                flagsNext[flagC] = ~subDiff[dataWidth];   // Not borrow
                flagsNext[flagV] = (decOpFirst[msb] ^ decOpSec[msb])
                                 & (decOpFirst[msb] ^ result[msb]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
            exeValid <= 1'b0;
            exeKind <= opNone;
        end else begin
            flags <= flagsNext;
            exeValid <= decValid;
            exeKind <= decKind;
        end
    end

    always_ff @(posedge clk) begin
        exeDest <= decDest;
        exeResult <= result;
        exeStoreData <= decOpDest;
        exeTaken <= condTaken;
        exeTarget <= target;
    end

endmodule

// File: hw/decodeStage.sv
module decodeStage
    import isaPkg::*, execPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic instrValid,
    input  instrWord instr,
    input  logic [dataWidth-1:0] opDest,
    input  logic [dataWidth-1:0] opFirst,
    input  logic [dataWidth-1:0] opSec,
    output logic decValid,
    output opKind decKind,
    output logic decSetFlags,
    output logic [3:0] decCond,
    output logic [regIndexWidth-1:0] decDest,
    output logic [dataWidth-1:0] decImm,
    output logic [immWidth-1:0] decImmRaw,
    output logic [dataWidth-1:0] decOpDest,
    output logic [dataWidth-1:0] decOpFirst,
    output logic [dataWidth-1:0] decOpSec
);

    opKind kind;
    logic setFlags;
    logic [immWidth-1:0] immRaw;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] secVal;

    function automatic opKind aluKind(input logic [3:0] func);
        case (func)
            funcAdd, funcAdds: aluKind = opAdd;
            funcSub, funcSubs: aluKind = opSub;
            funcAnd, funcAnds: aluKind = opAnd;
            funcOr, funcOrs: aluKind = opOr;
            funcXor, funcXors: aluKind = opXor;
            funcNot: aluKind = opNot;
            default: aluKind = opNone;
        endcase
    endfunction

    function automatic opKind moveKind(input logic [3:0] code);
        case (code)
            moveMov: moveKind = opPassImm;
            moveMovt: moveKind = opMoveTop;
            moveClr: moveKind = opZero;
            moveSet: moveKind = opOnes;
            moveLsl: moveKind = opShiftLeft;
            moveLsr: moveKind = opShiftRight;
            moveMovf: moveKind = opReadFlags;
            moveSavf: moveKind = opWriteFlags;
            default: moveKind = opNone;
        endcase
    endfunction

    // Immediate sits in bits 15:0 in both the immediate and branch views
    assign immRaw = instr.immediateView.imm;
    assign immExt = {{(dataWidth - immWidth){immRaw[immWidth-1]}}, immRaw};

    always_comb begin
        kind = opNone;
        setFlags = 1'b0;
        secVal = opSec;
        case (instr.registerView.cls)
            classRegister: begin
                kind = aluKind(instr.registerView.func);
                setFlags = (kind != opNone) && instr.registerView.func[3];
            end
            classImmediate: begin
                if (instr.immediateView.special) begin
                    kind = aluKind(instr.immediateView.func);
                    setFlags = (kind != opNone) && instr.immediateView.func[3];
                    secVal = immExt;                 // Immediate replaces second source
                end else begin
                    kind = moveKind(instr.immediateView.func);
                end
            end
            classLoadStore: kind = instr.immediateView.special ? opStore : opLoad;
            classBranch: kind = opBranch;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            decValid <= 1'b0;
            decKind <= opNone;
            decSetFlags <= 1'b0;
        end else begin
            decValid <= instrValid;
            decKind <= kind;
            decSetFlags <= setFlags;
        end
    end

    always_ff @(posedge clk) begin
        decCond <= instr.branchView.cond;
        decDest <= instr.registerView.dest;
        decImm <= immExt;
        decImmRaw <= immRaw;
        decOpDest <= opDest;
        decOpFirst <= opFirst;
        decOpSec <= secVal;
    end

endmodule

// File: hw/branchCondition.sv
module branchCondition
    import isaPkg::*, execPkg::*;
(
    input  logic [3:0] cond,
    input  flagWord flags,
    output logic taken
);

    logic n;
    logic z;
    logic c;
    logic v;
    logic hi;
    logic ge;

    assign n = flags[flagN];
    assign z = flags[flagZ];
    assign c = flags[flagC];
    assign v = flags[flagV];
    assign hi = c & ~z;     // Unsigned higher
    assign ge = (n == v);   // Signed greater or equal

    always_comb begin
        case (cond)
            condEq: taken = z;
            condNe: taken = ~z;
            condHs: taken = c;
            condLo: taken = ~c;
            condMi: taken = n;
            condPl: taken = ~n;
            condVs: taken = v;
            condVc: taken = ~v;
            condHi: taken = hi;
            condLs: taken = ~hi;
            condGe: taken = ge;
            condLt: taken = ~ge;
            condGt: taken = ~z & ge;
            condLe: taken = ~(~z & ge);
            condBr: taken = 1'b1;
            default: taken = 1'b0;     // Code 1111 is unassigned
        endcase
    end

endmodule

// File: hw/execPkg.sv
package execPkg;

    localparam int kindWidth = 5;
    localparam int flagWidth = 4;
    localparam int shiftWidth = 5;      // Shift amount from the low immediate bits
    localparam int targetWidth = 16;    // Branch target width

    typedef enum logic [kindWidth-1:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opNot,
        opPassImm,      // MOV
        opMoveTop,      // MOVT
        opZero,         // CLR
        opOnes,         // SET
        opShiftLeft,
        opShiftRight,
        opReadFlags,    // MOVF
        opWriteFlags,   // SAVF
        opLoad,
        opStore,
        opBranch,
        opNone
    } opKind;

    // NZCV bit positions
    localparam int flagN = 3;
    localparam int flagZ = 2;
    localparam int flagC = 1;
    localparam int flagV = 0;

    typedef logic [flagWidth-1:0] flagWord;

endpackage

// File: hw/isaPkg.sv
package isaPkg;

    localparam int dataWidth = 32;
    localparam int immWidth = 16;
    localparam int regIndexWidth = 4;

    // Instruction class, bits 31:30
    localparam logic [1:0] classImmediate = 2'b00;
    localparam logic [1:0] classRegister = 2'b01;
    localparam logic [1:0] classLoadStore = 2'b10;
    localparam logic [1:0] classBranch = 2'b11;

    // ALU functions, same codes for register and immediate forms
    localparam logic [3:0] funcAdd = 4'b0001;
    localparam logic [3:0] funcSub = 4'b0010;
    localparam logic [3:0] funcAnd = 4'b0011;
    localparam logic [3:0] funcOr = 4'b0100;
    localparam logic [3:0] funcXor = 4'b0101;
    localparam logic [3:0] funcNot = 4'b0110;
    localparam logic [3:0] funcAdds = 4'b1001;   // Bit 3 marks the flag-setting variant
    localparam logic [3:0] funcSubs = 4'b1010;
    localparam logic [3:0] funcAnds = 4'b1011;
    localparam logic [3:0] funcOrs = 4'b1100;
    localparam logic [3:0] funcXors = 4'b1101;

    // Move group, immediate class with the special bit clear
    localparam logic [3:0] moveMov = 4'b0000;
    localparam logic [3:0] moveMovt = 4'b0001;
    localparam logic [3:0] moveClr = 4'b0010;
    localparam logic [3:0] moveSet = 4'b0011;
    localparam logic [3:0] moveLsl = 4'b0100;
    localparam logic [3:0] moveLsr = 4'b0101;
    localparam logic [3:0] moveMovf = 4'b0110;
    localparam logic [3:0] moveSavf = 4'b1110;

    // Branch conditions
    localparam logic [3:0] condEq = 4'b0000;
    localparam logic [3:0] condNe = 4'b0001;
    localparam logic [3:0] condHs = 4'b0010;
    localparam logic [3:0] condLo = 4'b0011;
    localparam logic [3:0] condMi = 4'b0100;
    localparam logic [3:0] condPl = 4'b0101;
    localparam logic [3:0] condVs = 4'b0110;
    localparam logic [3:0] condVc = 4'b0111;
    localparam logic [3:0] condHi = 4'b1000;
    localparam logic [3:0] condLs = 4'b1001;
    localparam logic [3:0] condGe = 4'b1010;
    localparam logic [3:0] condLt = 4'b1011;
    localparam logic [3:0] condGt = 4'b1100;
    localparam logic [3:0] condLe = 4'b1101;
    localparam logic [3:0] condBr = 4'b1110;     // Register relative, always taken

    typedef struct packed {
        logic [1:0] cls;
        logic special;
        logic [3:0] func;
        logic spare;                             // Bit 24, reserved
        logic [regIndexWidth-1:0] dest;
        logic [regIndexWidth-1:0] first;
        logic [regIndexWidth-1:0] sec;
        logic [11:0] unused;
    } registerFields;

    // Special bit also picks store over load in the load/store class
    typedef struct packed {
        logic [1:0] cls;
        logic special;
        logic [3:0] func;
        logic spare;
        logic [regIndexWidth-1:0] dest;
        logic [regIndexWidth-1:0] first;
        logic [immWidth-1:0] imm;
    } immediateFields;

    typedef struct packed {
        logic [1:0] cls;
        logic [3:0] cond;
        logic [5:0] unused;
        logic [regIndexWidth-1:0] first;
        logic [immWidth-1:0] imm;
    } branchFields;

    typedef union packed {
        registerFields registerView;
        immediateFields immediateView;
        branchFields branchView;
    } instrWord;

endpackage
